/* include/trace_params.svh */
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

////////////////////////////////////////////////////////////
// Trace collector sizing
////////////////////////////////////////////////////////////

// One table entry per in-flight tag
`define TRACE_DEPTH 16

`define CYC_W       12  // Cycle stamps wrap at 4096
`define OUTQ_DEPTH  4   // Record queue ahead of the writer
`define RAM_WORDS   64  // 32-bit words, two per record

`endif

/* src/trace_pkg.sv */
`include "trace_params.svh"

package trace_pkg;

    ////////////////////////////////////////////////////////////
    // Core event and trace record types
    ////////////////////////////////////////////////////////////

    typedef logic [$clog2(`TRACE_DEPTH)-1:0] tag_t;    // Instruction tag from core
    typedef logic [`CYC_W-1:0]               cyc_t;    // Cycle stamp
    typedef logic [3:0]                      stall_t;  // Saturating stall count

    typedef struct packed {
        logic        valid;
        tag_t        tag;
        logic [31:0] pc;
    } fetch_evt_t;

    // Shared by stall, retire and flush
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_evt_t;

    // Upper half is RAM word 0, lower half is word 1
    typedef struct packed {
        logic [31:0] pc;
        cyc_t        fetch_cyc;  // Top bits of word 1
        cyc_t        end_cyc;    // Retire or flush stamp
        stall_t      stalls;
        logic        flushed;
        logic [2:0]  rsvd;       // Always zero
    } trace_rec_t;

endpackage

/* src/bus_pkg.sv */
`include "trace_params.svh"

package bus_pkg;

    ////////////////////////////////////////////////////////////
    // Wishbone classic and host port types
    ////////////////////////////////////////////////////////////

    localparam int ADR_W = $clog2(`RAM_WORDS);  // Word address width

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [31:0]      dat;  // Write data
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;  // Read data
    } wb_rsp_t;

    typedef struct packed {
        logic             valid;
        logic [ADR_W-1:0] adr;
    } host_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] dat;
    } host_rsp_t;

endpackage

/* src/lifecycle_table.sv */
`timescale 1ns/1ns
`include "trace_params.svh"

module lifecycle_table (
    input  logic                   clk,
    input  logic                   rst,
    input  trace_pkg::fetch_evt_t  fetch_evt,
    input  trace_pkg::tag_evt_t    stall_evt,
    input  trace_pkg::tag_evt_t    retire_evt,
    input  trace_pkg::tag_evt_t    flush_evt,
    input  logic                   rec_ready,
    output trace_pkg::trace_rec_t  rec,
    output logic                   rec_valid,
    output logic [7:0]             trace_dropped
);

    localparam int QA_W = $clog2(`OUTQ_DEPTH);
    localparam int QC_W = QA_W + 1;

    logic [31:0]           ent_pc     [`TRACE_DEPTH];
    trace_pkg::cyc_t       ent_fcyc   [`TRACE_DEPTH];
    trace_pkg::stall_t     ent_stalls [`TRACE_DEPTH];
    trace_pkg::trace_rec_t outq       [`OUTQ_DEPTH];

    trace_pkg::cyc_t       cyc_cnt;
    trace_pkg::trace_rec_t ret_rec, fl_rec;
    logic [QA_W-1:0]       wr_ptr, rd_ptr;
    logic [QC_W-1:0]       q_cnt, q_free;
    logic                  push_ret, push_fl, pop;
    logic [1:0]            n_push, n_drop;

    function automatic trace_pkg::trace_rec_t make_rec(
        input logic [31:0]       pc,
        input trace_pkg::cyc_t   fcyc,
        input trace_pkg::cyc_t   ecyc,
        input trace_pkg::stall_t stalls,
        input logic              flushed
    );
        trace_pkg::trace_rec_t r;
        r           = '0;
        r.pc        = pc;
        r.fetch_cyc = fcyc;
        r.end_cyc   = ecyc;
        r.stalls    = stalls;
        r.flushed   = flushed;
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Per-tag entries
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (stall_evt.valid && ent_stalls[stall_evt.tag] != 4'hf) begin  // Saturate at 15
            ent_stalls[stall_evt.tag] <= ent_stalls[stall_evt.tag] + 4'd1;
        end
        if (fetch_evt.valid) begin
            ent_pc[fetch_evt.tag]     <= fetch_evt.pc;
            ent_fcyc[fetch_evt.tag]   <= cyc_cnt;
            ent_stalls[fetch_evt.tag] <= '0;  // Overrides a same-cycle stall
        end
    end

    assign ret_rec = make_rec(ent_pc[retire_evt.tag], ent_fcyc[retire_evt.tag], cyc_cnt,
                              ent_stalls[retire_evt.tag], 1'b0);
    assign fl_rec  = make_rec(ent_pc[flush_evt.tag], ent_fcyc[flush_evt.tag], cyc_cnt,
                              ent_stalls[flush_evt.tag], 1'b1);

    ////////////////////////////////////////////////////////////
    // Record queue with retire ahead of flush
    ////////////////////////////////////////////////////////////

    assign q_free   = QC_W'(`OUTQ_DEPTH) - q_cnt;
    assign push_ret = retire_evt.valid && q_free != '0;
    assign push_fl  = flush_evt.valid && q_free > QC_W'(push_ret);
    assign n_push   = {1'b0, push_ret} + {1'b0, push_fl};
    assign n_drop   = {1'b0, retire_evt.valid && !push_ret} + {1'b0, flush_evt.valid && !push_fl};
    assign pop      = rec_valid && rec_ready;

    assign rec       = outq[rd_ptr];
    assign rec_valid = q_cnt != '0;

    always_ff @(posedge clk) begin
        if (push_ret || push_fl) begin
            outq[wr_ptr] <= push_ret ? ret_rec : fl_rec;
        end
        if (push_ret && push_fl) begin
            outq[wr_ptr + QA_W'(1)] <= fl_rec;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc_cnt       <= '0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            q_cnt         <= '0;
            trace_dropped <= '0;
        end else begin
            cyc_cnt       <= cyc_cnt + 1'b1;  // Free running stamp
            wr_ptr        <= wr_ptr + QA_W'(n_push);
            rd_ptr        <= rd_ptr + QA_W'(pop);
            q_cnt         <= q_cnt + QC_W'(n_push) - QC_W'(pop);
            trace_dropped <= trace_dropped + 8'(n_drop);
        end
    end

endmodule

/* src/trace_writer.sv */
`timescale 1ns/1ns

module trace_writer (
    input  logic                  clk,
    input  logic                  rst,
    input  trace_pkg::trace_rec_t rec,
    input  logic                  rec_valid,
    input  bus_pkg::wb_rsp_t      wb_rsp,
    output logic                  rec_ready,
    output bus_pkg::wb_req_t      wb_req,
    output logic [15:0]           rec_count
);

    typedef enum logic [1:0] {
        IDLE,
        WR_W0,  // PC word
        WR_W1   // Stamps and flags
    } state_t;

    state_t                    state;
    trace_pkg::trace_rec_t     rec_q;
    logic [bus_pkg::ADR_W-1:0] wr_ptr;  // Even word address of next record

    assign rec_ready = state == IDLE;

    assign wb_req.cyc = state != IDLE;
    assign wb_req.stb = state != IDLE;
    assign wb_req.we  = 1'b1;
    assign wb_req.adr = (state == WR_W1) ? wr_ptr + 1'b1 : wr_ptr;
    assign wb_req.dat = (state == WR_W1) ? rec_q[31:0] : rec_q.pc;

    always_ff @(posedge clk) begin
        if (rec_valid && rec_ready) rec_q <= rec;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            wr_ptr    <= '0;
            rec_count <= '0;
        end else begin
            case (state)
                IDLE:    if (rec_valid) state <= WR_W0;
                WR_W0:   if (wb_rsp.ack) state <= WR_W1;
                default: if (wb_rsp.ack) begin
                    state     <= IDLE;
                    wr_ptr    <= wr_ptr + 2'd2;  // Wraps with the ring
                    rec_count <= rec_count + 16'd1;
                end
            endcase
        end
    end

endmodule

/* src/host_reader.sv */
`timescale 1ns/1ns

module host_reader (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::host_req_t host_req,
    input  bus_pkg::wb_rsp_t   wb_rsp,
    output logic               host_busy,
    output bus_pkg::host_rsp_t host_rsp,
    output bus_pkg::wb_req_t   wb_req
);

    logic [bus_pkg::ADR_W-1:0] adr_q;
    logic [31:0]               dat_q;
    logic                      rsp_valid;

    // Busy doubles as the bus request
    assign wb_req.cyc = host_busy;
    assign wb_req.stb = host_busy;
    assign wb_req.we  = 1'b0;
    assign wb_req.adr = adr_q;
    assign wb_req.dat = '0;

    assign host_rsp.valid = rsp_valid;
    assign host_rsp.dat   = dat_q;

    always_ff @(posedge clk) begin
        if (!host_busy && host_req.valid) adr_q <= host_req.adr;
        if (host_busy && wb_rsp.ack) dat_q <= wb_rsp.dat;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            host_busy <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= host_busy && wb_rsp.ack;  // Single-cycle pulse
            if (!host_busy && host_req.valid) host_busy <= 1'b1;
            else if (wb_rsp.ack) host_busy <= 1'b0;
        end
    end

endmodule

/* src/wb_arbiter.sv */
`timescale 1ns/1ns

module wb_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t m0_req,
    input  bus_pkg::wb_req_t m1_req,
    input  bus_pkg::wb_rsp_t s_rsp,
    output bus_pkg::wb_rsp_t m0_rsp,
    output bus_pkg::wb_rsp_t m1_rsp,
    output bus_pkg::wb_req_t s_req
);

    logic locked;  // A transfer is in progress
    logic owner;   // Master holding the bus while locked
    logic prio;    // Winner of the next tie
    logic gnt;
    logic m0_want, m1_want;

    assign m0_want = m0_req.cyc && m0_req.stb;
    assign m1_want = m1_req.cyc && m1_req.stb;

    ////////////////////////////////////////////////////////////
    // New grants only on an idle bus
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (locked)                 gnt = owner;
        else if (m0_want && m1_want) gnt = prio;
        else                        gnt = m1_want;
    end

    assign s_req = gnt ? m1_req : m0_req;

    assign m0_rsp.ack = s_rsp.ack && locked && !owner;
    assign m1_rsp.ack = s_rsp.ack && locked && owner;
    assign m0_rsp.dat = s_rsp.dat;
    assign m1_rsp.dat = s_rsp.dat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= 1'b0;
            prio   <= 1'b0;
        end else if (locked && s_rsp.ack) begin
            locked <= 1'b0;
            prio   <= ~owner;  // Other master goes first next time
        end else if (!locked && (m0_want || m1_want)) begin
            locked <= 1'b1;
            owner  <= gnt;
        end
    end

endmodule

/* src/trace_ram.sv */
`timescale 1ns/1ns
`include "trace_params.svh"

module trace_ram (
    input  logic             clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t wb_req,
    output bus_pkg::wb_rsp_t wb_rsp
);

    logic [31:0] mem [`RAM_WORDS];
    logic [31:0] rd_q;
    logic        ack_q;
    logic        hit;

    assign hit = wb_req.cyc && wb_req.stb;

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;

    // Read data lines up with the registered ack
    always_ff @(posedge clk) begin
        if (hit && !ack_q) rd_q <= mem[wb_req.adr];
        if (ack_q && hit && wb_req.we) begin
            mem[wb_req.adr] <= wb_req.dat;  // Request still held during ack
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit && !ack_q;  // Low after every ack
        end
    end

endmodule

/* src/trace_unit_top.sv */
`timescale 1ns/1ns

module trace_unit_top (
    input  logic                  clk,
    input  logic                  rst,
    input  trace_pkg::fetch_evt_t fetch_evt,
    input  trace_pkg::tag_evt_t   stall_evt,
    input  trace_pkg::tag_evt_t   retire_evt,
    input  trace_pkg::tag_evt_t   flush_evt,
    input  bus_pkg::host_req_t    host_req,
    output logic                  host_busy,
    output bus_pkg::host_rsp_t    host_rsp,
    output logic [15:0]           rec_count,
    output logic [7:0]            trace_dropped
);

    trace_pkg::trace_rec_t rec;
    logic                  rec_valid, rec_ready;
    bus_pkg::wb_req_t      wr_req, rd_req, ram_req;
    bus_pkg::wb_rsp_t      wr_rsp, rd_rsp, ram_rsp;

    lifecycle_table i_lifecycle_table (
        .clk, .rst, .fetch_evt, .stall_evt, .retire_evt, .flush_evt,
        .rec_ready, .rec, .rec_valid, .trace_dropped
    );

    trace_writer i_trace_writer (
        .clk, .rst, .rec, .rec_valid, .wb_rsp(wr_rsp),
        .rec_ready, .wb_req(wr_req), .rec_count
    );

    host_reader i_host_reader (
        .clk, .rst, .host_req, .wb_rsp(rd_rsp),
        .host_busy, .host_rsp, .wb_req(rd_req)
    );

    // Writer on port 0, host on port 1
    wb_arbiter i_wb_arbiter (
        .clk, .rst, .m0_req(wr_req), .m1_req(rd_req), .s_rsp(ram_rsp),
        .m0_rsp(wr_rsp), .m1_rsp(rd_rsp), .s_req(ram_req)
    );

    trace_ram i_trace_ram (
        .clk, .rst, .wb_req(ram_req), .wb_rsp(ram_rsp)
    );

endmodule

/* tb/trace_unit_asserts.sv */
`timescale 1ns/1ns

module trace_unit_asserts (
    input logic             clk,
    input logic             rst,
    input bus_pkg::wb_req_t s_req,
    input bus_pkg::wb_rsp_t s_rsp
);

    ////////////////////////////////////////////////////////////
    // Wishbone classic checks on the slave side
    ////////////////////////////////////////////////////////////

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        s_rsp.ack |-> s_req.cyc && s_req.stb)
        else $error("Slave ack without cyc and stb");

    single_ack: assert property (@(posedge clk) disable iff (rst)
        s_rsp.ack |=> !s_rsp.ack)
        else $error("Slave ack high on two consecutive cycles");

    // Request may only change once it has been acknowledged
    req_held: assert property (@(posedge clk) disable iff (rst)
        s_req.stb && !s_rsp.ack |=> $stable(s_req))
        else $error("Slave request changed before ack");

endmodule

bind wb_arbiter trace_unit_asserts i_trace_unit_asserts (.*);

/* tb/trace_unit_tb.sv */
`timescale 1ns/1ns
`include "trace_params.svh"

module trace_unit_tb;

    typedef enum logic [1:0] {EV_FETCH, EV_STALL, EV_RETIRE, EV_FLUSH} ev_kind_t;

    typedef struct packed {
        int              off;   // Counter value when the event is driven
        ev_kind_t        kind;
        trace_pkg::tag_t tag;
        logic [31:0]     pc;
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst;
    trace_pkg::fetch_evt_t fetch_evt;
    trace_pkg::tag_evt_t   stall_evt, retire_evt, flush_evt;
    bus_pkg::host_req_t    host_req;
    logic                  host_busy;
    bus_pkg::host_rsp_t    host_rsp;
    logic [15:0]           rec_count;
    logic [7:0]            trace_dropped;

    row_t                  rows[$];
    trace_pkg::trace_rec_t exp_recs[$];   // Expected records in write order
    logic [31:0]           m_pc     [`TRACE_DEPTH];
    trace_pkg::cyc_t       m_fcyc   [`TRACE_DEPTH];
    trace_pkg::stall_t     m_stalls [`TRACE_DEPTH];
    logic [15:0]           lfsr = 16'd58214;
    int                    tb_cyc, run_cyc, n_mismatch, n_other;
    int                    cyc_limit = 100000;

    trace_unit_top i_trace_unit_top (
        .clk, .rst, .fetch_evt, .stall_evt, .retire_evt, .flush_evt,
        .host_req, .host_busy, .host_rsp, .rec_count, .trace_dropped
    );

    always #5 clk = ~clk;

    // Mirrors the table's stamp counter
    always @(posedge clk or posedge rst) begin
        if (rst) tb_cyc <= 0;
        else     tb_cyc <= tb_cyc + 1;
    end

    always @(posedge clk) begin
        run_cyc = run_cyc + 1;
        if (run_cyc >= cyc_limit) begin
            $display("Run stopped at the cycle limit of %0d cycles", run_cyc);
            $display("Errors: %0d value mismatches, %0d other failures", n_mismatch, n_other);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_pc();
        logic [31:0] pc;
        pc = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};  // x16+x14+x13+x11
            pc   = {pc[30:0], lfsr[0]};
        end
        return pc;
    endfunction

    // Fetch, stalls on the following cycles, then retire or flush
    function automatic int add_insn(input int start, input int tag, input int stalls,
                                    input logic flush);
        rows.push_back(row_t'{start, EV_FETCH, trace_pkg::tag_t'(tag), next_pc()});
        for (int i = 1; i <= stalls; i++) begin
            rows.push_back(row_t'{start + i, EV_STALL, trace_pkg::tag_t'(tag), 32'd0});
        end
        rows.push_back(row_t'{start + stalls + 2, flush ? EV_FLUSH : EV_RETIRE,
                              trace_pkg::tag_t'(tag), 32'd0});
        return start + stalls + 2;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_events();
        fetch_evt  = '0;
        stall_evt  = '0;
        retire_evt = '0;
        flush_evt  = '0;
    endtask

    task automatic apply_rows(input int first, input int last);
        row_t r;
        for (int i = first; i < last; i++) begin
            r = rows[i];
            if (tb_cyc > r.off) begin
                n_other++;
                $display("Stimulus row %0d missed its cycle %0d", i, r.off);
            end
            while (tb_cyc < r.off) step();
            case (r.kind)
                EV_FETCH: begin
                    fetch_evt         = '{1'b1, r.tag, r.pc};
                    m_pc[r.tag]       = r.pc;
                    m_fcyc[r.tag]     = trace_pkg::cyc_t'(tb_cyc);
                    m_stalls[r.tag]   = '0;
                end
                EV_STALL: begin
                    stall_evt = '{1'b1, r.tag};
                    if (m_stalls[r.tag] != 4'hf) m_stalls[r.tag] = m_stalls[r.tag] + 4'd1;
                end
                default: begin
                    if (r.kind == EV_FLUSH) flush_evt = '{1'b1, r.tag};
                    else                    retire_evt = '{1'b1, r.tag};
                    exp_recs.push_back(trace_pkg::trace_rec_t'{m_pc[r.tag], m_fcyc[r.tag],
                        trace_pkg::cyc_t'(tb_cyc), m_stalls[r.tag], r.kind == EV_FLUSH, 3'b0});
                end
            endcase
            step();
            clear_events();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Host reads and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            n_mismatch++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_rec(input string name, input trace_pkg::trace_rec_t exp,
                             input trace_pkg::trace_rec_t act);
        if (act !== exp) begin
            n_mismatch++;
            $display("[FAIL] %s: expected %016h, actual %016h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            n_mismatch++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic host_read(input logic [5:0] adr, output logic [31:0] dat);
        int waited;
        waited   = 0;
        host_req = '{1'b1, adr};
        step();
        host_req = '0;
        if (!host_busy) begin
            n_other++;
            $display("Host read of word %0d was not accepted", adr);
        end
        while (!host_rsp.valid && waited < 40) begin
            step();
            waited++;
        end
        if (!host_rsp.valid) begin
            n_other++;
            $display("Host read of word %0d never returned data", adr);
        end
        if (host_busy) begin
            n_other++;
            $display("host_busy still high when the read of word %0d returned", adr);
        end
        dat = host_rsp.dat;
    endtask

    // Record n sits at words 2n and 2n+1 of the ring
    task automatic read_rec(input int n);
        logic [31:0] w0, w1;
        host_read(6'(2 * (n % 32)), w0);
        host_read(6'(2 * (n % 32) + 1), w1);
        check_rec($sformatf("record %0d", n), exp_recs[n], {w0, w1});
    endtask

    task automatic wait_total(input int target);
        int waited;
        waited = 0;
        while (int'(rec_count) + int'(trace_dropped) != target && waited < 100) begin
            step();
            waited++;
        end
        check_count("records plus drops", 16'(target), rec_count + 16'(trace_dropped));
    endtask

    initial begin
        int          a, n_a, n_b, c_base;
        logic [31:0] rd, exp_w;
        rst = 1'b1;
        clear_events();
        host_req = '0;

        a   = add_insn(2, 0, 0, 1'b0);      // Plain retirements
        a   = add_insn(a + 6, 1, 0, 1'b0);
        a   = add_insn(a + 6, 2, 3, 1'b0);  // Three stalls
        a   = add_insn(a + 6, 3, 20, 1'b0); // Saturates at 15
        a   = add_insn(a + 6, 4, 0, 1'b1);  // Flushed
        n_a = rows.size();
        for (int n = 5; n < 36; n++) a = add_insn(150 + (n - 5) * 8, n % 16, 0, 1'b0);
        n_b    = rows.size();
        c_base = 450;
        for (int t = 0; t < 8; t++) begin
            rows.push_back(row_t'{c_base + t, EV_FETCH, 4'(8 + t), next_pc()});
        end
        for (int t = 0; t < 8; t++) begin
            rows.push_back(row_t'{c_base + 8 + t, EV_RETIRE, 4'(8 + t), 32'd0});
        end
        cyc_limit = 2 * rows[rows.size() - 1].off + 40 * 16;  // 16 host reads

        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        check_count("reset rec_count", 16'd0, rec_count);
        check_count("reset trace_dropped", 16'd0, 16'(trace_dropped));
        check_count("reset host_busy", 16'd0, 16'(host_busy));
        check_count("reset host_rsp valid", 16'd0, 16'(host_rsp.valid));

        apply_rows(0, n_a);
        wait_total(5);
        for (int n = 0; n < 5; n++) read_rec(n);

        apply_rows(n_a, n_b);
        wait_total(36);
        check_count("rec_count after 36", 16'd36, rec_count);
        read_rec(32);                    // Ring wrapped onto words 0 and 1

        fork
            apply_rows(n_b, rows.size());
            begin
                while (tb_cyc < c_base + 8) step();
                // Words 40 to 43 still hold records 20 and 21
                for (int i = 0; i < 4; i++) begin
                    host_read(6'(40 + i), rd);
                    exp_w = (i % 2 == 0) ? exp_recs[20 + i / 2].pc : exp_recs[20 + i / 2][31:0];
                    check_word($sformatf("word %0d during burst", 40 + i), exp_w, rd);
                end
            end
        join
        wait_total(44);

        $display("Errors: %0d value mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
src/trace_pkg.sv
src/bus_pkg.sv
src/lifecycle_table.sv
src/trace_writer.sv
src/host_reader.sv
src/wb_arbiter.sv
src/trace_ram.sv
src/trace_unit_top.sv
tb/trace_unit_asserts.sv
tb/trace_unit_tb.sv
